//--- src/soc_pkg.sv
package soc_pkg;

    // bus word and address are both 64 bits wide
    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;

    // load codes, stores reuse 000 to 011
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_e;

    // requester side, strobes are one-cycle pulses
    typedef struct packed {
        logic     read;
        logic     write;
        ls_type_e ls_type;
        addr_t    addr;
        data_t    wdata;
    } bus_req_t;

    // done flags sit high while idle
    typedef struct packed {
        data_t rdata;
        logic  read_done;
        logic  write_done;
    } bus_rsp_t;

    // one-hot, exactly one bit per decoded address
    typedef struct packed {
        logic ram;
        logic mtime;
        logic mtimecmp;
        logic plic;
        logic none;
    } target_sel_t;

    // interrupt controller register kinds
    typedef enum logic [2:0] {
        PREG_PRIORITY,
        PREG_PENDING,
        PREG_ENABLE0,
        PREG_ENABLE1,
        PREG_THRESHOLD0,
        PREG_THRESHOLD1,
        PREG_CLAIM0,
        PREG_CLAIM1
    } plic_reg_e;

    // address map
    localparam addr_t RAM_BASE        = 64'h0000_1000;
    localparam addr_t MTIME_ADDR      = 64'h0200_BFF8;
    localparam addr_t MTIMECMP_ADDR   = 64'h0200_4000;
    localparam addr_t PLIC_BASE       = 64'h0C00_0000;
    localparam addr_t PLIC_PENDING    = PLIC_BASE + 64'h1000;
    localparam addr_t PLIC_ENABLE0    = PLIC_BASE + 64'h2000;
    localparam addr_t PLIC_ENABLE1    = PLIC_ENABLE0 + 64'h80;
    localparam addr_t PLIC_THRESHOLD0 = PLIC_BASE + 64'h20_0000;
    localparam addr_t PLIC_CLAIM0     = PLIC_BASE + 64'h20_0004;
    localparam addr_t PLIC_THRESHOLD1 = PLIC_THRESHOLD0 + 64'h1000;
    localparam addr_t PLIC_CLAIM1     = PLIC_CLAIM0 + 64'h1000;

    // interrupt sources 1..NUM_SOURCES, id 0 means none
    localparam int NUM_SOURCES = 5;
    typedef logic [2:0] prio_t;
    // bit n-1 holds source n
    typedef logic [NUM_SOURCES-1:0] src_vec_t;

    localparam data_t MTIMECMP_RESET = 64'h8000_0000;

endpackage

//--- src/bus_decoder.sv
`timescale 1ns/100ps

module bus_decoder #(
    parameter int RAM_WORDS = 1024
) (
    input  soc_pkg::addr_t      addr,
    output soc_pkg::target_sel_t sel,
    output soc_pkg::plic_reg_e  plic_reg,
    output logic [2:0]          plic_id
);
    import soc_pkg::*;

    localparam addr_t RAM_END = RAM_BASE + addr_t'(RAM_WORDS) * 64'd4;
    // priority window covers ids 0..NUM_SOURCES only
    localparam addr_t PRIO_END = PLIC_BASE + addr_t'(4 * (NUM_SOURCES + 1));

    logic plic_hit;

    // id = offset / 4 inside the priority window
    assign plic_id = 3'((addr - PLIC_BASE) >> 2);

    always_comb begin
        plic_hit = 1'b1;
        plic_reg = PREG_PRIORITY;
        if (addr >= PLIC_BASE && addr < PRIO_END) begin
            plic_reg = PREG_PRIORITY;
        end else begin
            case (addr)
                PLIC_PENDING:    plic_reg = PREG_PENDING;
                PLIC_ENABLE0:    plic_reg = PREG_ENABLE0;
                PLIC_ENABLE1:    plic_reg = PREG_ENABLE1;
                PLIC_THRESHOLD0: plic_reg = PREG_THRESHOLD0;
                PLIC_THRESHOLD1: plic_reg = PREG_THRESHOLD1;
                PLIC_CLAIM0:     plic_reg = PREG_CLAIM0;
                PLIC_CLAIM1:     plic_reg = PREG_CLAIM1;
                default:         plic_hit = 1'b0;
            endcase
        end
    end

    // priority chain keeps the select one-hot
    always_comb begin
        sel = '0;
        if (addr >= RAM_BASE && addr < RAM_END) begin
            sel.ram = 1'b1;
        end else if (addr == MTIME_ADDR) begin
            sel.mtime = 1'b1;
        end else if (addr == MTIMECMP_ADDR) begin
            sel.mtimecmp = 1'b1;
        end else if (plic_hit) begin
            sel.plic = 1'b1;
        end else begin
            // unmapped
            sel.none = 1'b1;
        end
    end

endmodule

//--- src/bus_sequencer.sv
`timescale 1ns/100ps

module bus_sequencer (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  soc_pkg::bus_req_t    bus_req,
    output soc_pkg::bus_rsp_t    bus_rsp,
    input  soc_pkg::target_sel_t sel,
    output soc_pkg::target_sel_t start,
    output soc_pkg::bus_req_t    req_q,
    input  logic                 ram_ack,
    input  logic                 timer_ack,
    input  logic                 plic_ack,
    input  soc_pkg::data_t       ram_rdata,
    input  soc_pkg::data_t       timer_rdata,
    input  soc_pkg::data_t       plic_rdata
);
    import soc_pkg::*;

    logic        idle;
    logic        strobe;
    // high in the cycle after the strobe
    logic        launch;
    target_sel_t active;
    logic        done_ack;
    data_t       ack_data;

    assign idle = bus_rsp.read_done && bus_rsp.write_done;
    // strobes while busy are dropped
    assign strobe = idle && (bus_req.read || bus_req.write);

    // decoder looks at req_q, so sel is valid during launch
    assign start = launch ? sel : '0;

    // route the ack and data of the active target
    always_comb begin
        done_ack = 1'b0;
        ack_data = '0;
        if (active.ram) begin
            done_ack = ram_ack;
            ack_data = ram_rdata;
        end else if (active.mtime || active.mtimecmp) begin
            done_ack = timer_ack;
            ack_data = timer_rdata;
        end else if (active.plic) begin
            done_ack = plic_ack;
            ack_data = plic_rdata;
        end else if (active.none) begin
            // nothing behind it, finish right away with zero
            done_ack = 1'b1;
        end
    end

    // request payload held for the whole transfer
    always_ff @(posedge CLOCK_50) begin
        if (strobe) begin
            req_q <= bus_req;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_rsp.rdata      <= '0;
            bus_rsp.read_done  <= 1'b1;
            bus_rsp.write_done <= 1'b1;
            launch             <= 1'b0;
            active             <= '0;
        end else begin
            launch <= strobe;
            if (strobe) begin
                bus_rsp.read_done  <= !bus_req.read;
                bus_rsp.write_done <= !bus_req.write;
            end
            if (launch) begin
                active <= sel;
            end else if (done_ack) begin
                // writes leave the last read data alone
                if (!bus_rsp.read_done) begin
                    bus_rsp.rdata <= ack_data;
                end
                bus_rsp.read_done  <= 1'b1;
                bus_rsp.write_done <= 1'b1;
                active             <= '0;
            end
        end
    end

endmodule

//--- src/word_ram.sv
`timescale 1ns/100ps

module word_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              start,
    input  soc_pkg::bus_req_t req,
    output logic              ack,
    output soc_pkg::data_t    rdata
);
    import soc_pkg::*;

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    addr_t         off_addr;
    logic [AW-1:0] idx;
    logic [1:0]    off;
    logic          dword;
    // upper half of ld/sd still to go
    logic          second;
    logic [3:0]    be;
    logic [31:0]   st_data;
    logic [31:0]   shifted;
    data_t         load_val;

    assign off_addr = req.addr - RAM_BASE;
    assign idx      = off_addr[AW+1:2];
    assign off      = req.addr[1:0];
    assign dword    = req.ls_type == LS_D;

    // byte lanes and replicated store data
    always_comb begin
        unique case (req.ls_type)
            LS_B: begin
                be      = 4'b0001 << off;
                st_data = {4{req.wdata[7:0]}};
            end
            LS_H: begin
                be      = 4'b0011 << off;
                st_data = {2{req.wdata[15:0]}};
            end
            default: begin
                be      = 4'b1111;
                st_data = req.wdata[31:0];
            end
        endcase
    end

    // shift the addressed bytes down, then extend
    always_comb begin
        shifted = mem[idx] >> {off, 3'b000};
        case (req.ls_type)
            LS_B:    load_val = {{56{shifted[7]}}, shifted[7:0]};
            LS_H:    load_val = {{48{shifted[15]}}, shifted[15:0]};
            LS_W:    load_val = {{32{shifted[31]}}, shifted};
            LS_BU:   load_val = {56'b0, shifted[7:0]};
            LS_HU:   load_val = {48'b0, shifted[15:0]};
            // lwu and the low beat of ld
            default: load_val = {32'b0, shifted};
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ack    <= 1'b0;
            second <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (start && dword) begin
                second <= 1'b1;
            end else if (second) begin
                second <= 1'b0;
                ack    <= 1'b1;
            end else if (start) begin
                ack <= 1'b1;
            end
        end
    end

    // low word first, high word on the next consecutive word
    always_ff @(posedge CLOCK_50) begin
        if (start && req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[idx][8*b +: 8] <= st_data[8*b +: 8];
                end
            end
        end
        if (second && req.write) begin
            mem[idx + 1'b1] <= req.wdata[63:32];
        end
        if (start && req.read) begin
            rdata <= load_val;
        end
        if (second && req.read) begin
            rdata[63:32] <= mem[idx + 1'b1];
        end
    end

endmodule

//--- src/clint_timer.sv
`timescale 1ns/100ps

module clint_timer (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              start,
    input  soc_pkg::bus_req_t req,
    input  logic              is_cmp,
    output logic              ack,
    output soc_pkg::data_t    rdata,
    output logic              mtip
);
    import soc_pkg::*;

    data_t mtime;
    data_t mtimecmp;

    // pending while the counter has reached the compare value
    assign mtip = mtime >= mtimecmp;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtime    <= '0;
            mtimecmp <= MTIMECMP_RESET;
            ack      <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            ack   <= start;
            // mtime itself ignores writes
            if (start && req.write && is_cmp) begin
                mtimecmp <= req.wdata;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (start && req.read) begin
            rdata <= is_cmp ? mtimecmp : mtime;
        end
    end

endmodule

//--- src/plic_lite.sv
`timescale 1ns/100ps

module plic_lite (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                start,
    input  soc_pkg::bus_req_t   req,
    input  soc_pkg::plic_reg_e  reg_kind,
    input  logic [2:0]          src_id,
    input  soc_pkg::src_vec_t   irq_src,
    output logic                ack,
    output soc_pkg::data_t      rdata,
    output logic                meip,
    output logic                seip
);
    import soc_pkg::*;

    prio_t      prio_q [NUM_SOURCES];
    src_vec_t   pending_q;
    src_vec_t   irq_q;
    src_vec_t   enable_q [2];
    prio_t      threshold_q [2];
    logic [2:0] claim_id [2];
    src_vec_t   claim_clr;
    logic       id_ok;

    // id 0 and ids past the last source have no priority register
    assign id_ok = src_id != 3'd0 && src_id <= 3'(NUM_SOURCES);

    // ctx 0 machine, ctx 1 supervisor
    assign meip = claim_id[0] != 3'd0;
    assign seip = claim_id[1] != 3'd0;

    // strictly above threshold, ties to the lowest id
    always_comb begin
        prio_t best;
        for (int c = 0; c < 2; c++) begin
            best        = threshold_q[c];
            claim_id[c] = 3'd0;
            for (int n = 0; n < NUM_SOURCES; n++) begin
                if (pending_q[n] && enable_q[c][n] && prio_q[n] > best) begin
                    best        = prio_q[n];
                    claim_id[c] = 3'(n + 1);
                end
            end
        end
    end

    // a claim read drops the pending bit of the id it returns
    always_comb begin
        claim_clr = '0;
        if (start && req.read) begin
            if (reg_kind == PREG_CLAIM0 && claim_id[0] != 3'd0) begin
                claim_clr[claim_id[0] - 3'd1] = 1'b1;
            end
            if (reg_kind == PREG_CLAIM1 && claim_id[1] != 3'd0) begin
                claim_clr[claim_id[1] - 3'd1] = 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending_q <= '0;
            irq_q     <= '0;
            ack       <= 1'b0;
            for (int n = 0; n < NUM_SOURCES; n++) begin
                prio_q[n] <= '0;
            end
            for (int c = 0; c < 2; c++) begin
                enable_q[c]    <= '0;
                threshold_q[c] <= '0;
            end
        end else begin
            irq_q <= irq_src;
            ack   <= start;
            // new edge wins over a claim in the same cycle
            pending_q <= (pending_q & ~claim_clr) | (irq_src & ~irq_q);
            // claim and pending writes only complete
            if (start && req.write) begin
                case (reg_kind)
                    PREG_PRIORITY: begin
                        if (id_ok) prio_q[src_id - 3'd1] <= req.wdata[2:0];
                    end
                    PREG_ENABLE0:    enable_q[0]    <= req.wdata[NUM_SOURCES:1];
                    PREG_ENABLE1:    enable_q[1]    <= req.wdata[NUM_SOURCES:1];
                    PREG_THRESHOLD0: threshold_q[0] <= req.wdata[2:0];
                    PREG_THRESHOLD1: threshold_q[1] <= req.wdata[2:0];
                    default: ;
                endcase
            end
        end
    end

    // bitmaps on the bus put source n at bit n, bit 0 reads zero
    always_ff @(posedge CLOCK_50) begin
        if (start && req.read) begin
            case (reg_kind)
                PREG_PRIORITY:   rdata <= id_ok ? data_t'(prio_q[src_id - 3'd1]) : '0;
                PREG_PENDING:    rdata <= data_t'({pending_q, 1'b0});
                PREG_ENABLE0:    rdata <= data_t'({enable_q[0], 1'b0});
                PREG_ENABLE1:    rdata <= data_t'({enable_q[1], 1'b0});
                PREG_THRESHOLD0: rdata <= data_t'(threshold_q[0]);
                PREG_THRESHOLD1: rdata <= data_t'(threshold_q[1]);
                PREG_CLAIM0:     rdata <= data_t'(claim_id[0]);
                default:         rdata <= data_t'(claim_id[1]);
            endcase
        end
    end

endmodule

//--- src/soc_bus.sv
`timescale 1ns/100ps

module soc_bus #(
    parameter int RAM_WORDS = 1024
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  soc_pkg::bus_req_t bus_req,
    output soc_pkg::bus_rsp_t bus_rsp,
    input  soc_pkg::src_vec_t irq_src,
    output logic              meip,
    output logic              seip,
    output logic              mtip
);
    import soc_pkg::*;

    target_sel_t sel;
    target_sel_t start;
    bus_req_t    req_q;
    plic_reg_e   plic_reg;
    logic [2:0]  plic_id;
    logic        ram_ack;
    logic        timer_ack;
    logic        plic_ack;
    data_t       ram_rdata;
    data_t       timer_rdata;
    data_t       plic_rdata;

    // decode runs on the held request
    bus_decoder #(.RAM_WORDS(RAM_WORDS)) bus_decoder_i (
        .addr     (req_q.addr),
        .sel      (sel),
        .plic_reg (plic_reg),
        .plic_id  (plic_id)
    );

    bus_sequencer bus_sequencer_i (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .sel         (sel),
        .start       (start),
        .req_q       (req_q),
        .ram_ack     (ram_ack),
        .timer_ack   (timer_ack),
        .plic_ack    (plic_ack),
        .ram_rdata   (ram_rdata),
        .timer_rdata (timer_rdata),
        .plic_rdata  (plic_rdata)
    );

    word_ram #(.RAM_WORDS(RAM_WORDS)) word_ram_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .start    (start.ram),
        .req      (req_q),
        .ack      (ram_ack),
        .rdata    (ram_rdata)
    );

    // one timer block serves both mtime and mtimecmp
    clint_timer clint_timer_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .start    (start.mtime | start.mtimecmp),
        .req      (req_q),
        .is_cmp   (start.mtimecmp),
        .ack      (timer_ack),
        .rdata    (timer_rdata),
        .mtip     (mtip)
    );

    plic_lite plic_lite_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .start    (start.plic),
        .req      (req_q),
        .reg_kind (plic_reg),
        .src_id   (plic_id),
        .irq_src  (irq_src),
        .ack      (plic_ack),
        .rdata    (plic_rdata),
        .meip     (meip),
        .seip     (seip)
    );

endmodule

//--- tests/soc_bus_assertions.sv
`timescale 1ns/100ps

module soc_bus_assertions (
    input logic              CLOCK_50,
    input logic              KEY0,
    input soc_pkg::bus_rsp_t bus_rsp
);
    import soc_pkg::*;

    // cycles spent with a done flag low
    int busy_cycles;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy_cycles <= 0;
        end else if (bus_rsp.read_done && bus_rsp.write_done) begin
            busy_cycles <= 0;
        end else begin
            busy_cycles <= busy_cycles + 1;
        end
    end

    // idle right out of reset
    assert property (@(posedge CLOCK_50) $rose(KEY0) |-> bus_rsp.read_done && bus_rsp.write_done)
        else $error("done flags low in the cycle after reset");

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) busy_cycles <= 6)
        else $error("done flag stayed low for more than 6 cycles");

    // only one transfer at a time
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
                     bus_rsp.read_done || bus_rsp.write_done)
        else $error("read_done and write_done both low");

endmodule

bind soc_bus soc_bus_assertions soc_bus_assertions_i (
    .CLOCK_50 (CLOCK_50),
    .KEY0     (KEY0),
    .bus_rsp  (bus_rsp)
);

//--- tests/soc_bus_tb.sv
`timescale 1ns/100ps

module soc_bus_tb;
    import soc_pkg::*;

    logic     CLOCK_50;
    logic     KEY0;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;
    src_vec_t irq_src;
    logic     meip;
    logic     seip;
    logic     mtip;

    // one bus operation, exp only used for reads
    typedef struct {
        bit       wr;
        ls_type_e ls;
        addr_t    addr;
        data_t    data;
        data_t    exp;
    } op_t;

    op_t        ops[$];
    // byte model of the low RAM window
    logic [7:0] ram_model [256];
    // interrupt controller model, index = source id
    prio_t      m_prio [NUM_SOURCES+1];
    src_vec_t   m_pend;
    src_vec_t   m_en [2];
    prio_t      m_thr [2];
    int         errors;
    int         checks;
    int         test_start;

    soc_bus #(.RAM_WORDS(1024)) soc_bus_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .irq_src  (irq_src),
        .meip     (meip),
        .seip     (seip),
        .mtip     (mtip)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    // overall limit in case a wait loop is skipped
    initial begin
        #2000000;
        $display("simulation stopped by the watchdog before the tests ended");
        $display("CHECKS FAILED");
        $finish;
    end

    // little endian read of the byte model, then extend by type
    function automatic data_t model_load(ls_type_e ls, addr_t a);
        int          o;
        logic [15:0] h;
        logic [31:0] w;
        logic [31:0] hi;
        o  = int'(a - RAM_BASE);
        h  = {ram_model[o+1], ram_model[o]};
        w  = {ram_model[o+3], ram_model[o+2], h};
        hi = {ram_model[o+7], ram_model[o+6], ram_model[o+5], ram_model[o+4]};
        case (ls)
            LS_B:    return {{56{ram_model[o][7]}}, ram_model[o]};
            LS_BU:   return {56'b0, ram_model[o]};
            LS_H:    return {{48{h[15]}}, h};
            LS_HU:   return {48'b0, h};
            LS_W:    return {{32{w[31]}}, w};
            LS_WU:   return {32'b0, w};
            default: return {hi, w};
        endcase
    endfunction

    function automatic void model_store(ls_type_e ls, addr_t a, data_t d);
        int o;
        int n;
        o = int'(a - RAM_BASE);
        n = 1 << int'(ls);
        for (int i = 0; i < n; i++) begin
            ram_model[o+i] = d[8*i +: 8];
        end
    endfunction

    // highest priority above threshold, lowest id on a tie
    function automatic logic [2:0] model_claim(int c);
        prio_t      best;
        logic [2:0] id;
        best = m_thr[c];
        id   = 3'd0;
        for (int n = 1; n <= NUM_SOURCES; n++) begin
            if (m_pend[n-1] && m_en[c][n-1] && m_prio[n] > best) begin
                best = m_prio[n];
                id   = 3'(n);
            end
        end
        return id;
    endfunction

    function automatic logic irq_level(int which);
        case (which)
            0:       return meip;
            1:       return seip;
            default: return mtip;
        endcase
    endfunction

    task automatic check_value(input data_t got, input data_t exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // strobe on a falling edge, then poll both done flags
    task automatic access(input bit wr, input ls_type_e ls, input addr_t a,
                          input data_t d, output data_t rd);
        int n;
        @(negedge CLOCK_50);
        bus_req.read    = !wr;
        bus_req.write   = wr;
        bus_req.ls_type = ls;
        bus_req.addr    = a;
        bus_req.wdata   = d;
        @(negedge CLOCK_50);
        bus_req.read  = 1'b0;
        bus_req.write = 1'b0;
        n = 0;
        while (!(bus_rsp.read_done && bus_rsp.write_done) && n < 20) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (!(bus_rsp.read_done && bus_rsp.write_done)) begin
            $display("timeout at %0t: no done flag for address %h after %0d cycles",
                     $time, a, n);
            errors++;
        end
        rd = bus_rsp.rdata;
    endtask

    task automatic read_check(input addr_t a, input data_t exp, input string what);
        data_t rd;
        access(1'b0, LS_D, a, '0, rd);
        check_value(rd, exp, what);
    endtask

    task automatic write_reg(input addr_t a, input data_t d);
        data_t rd;
        access(1'b1, LS_W, a, d, rd);
    endtask

    task automatic wait_high(input int which, input int limit, input string what);
        int n;
        n = 0;
        while (!irq_level(which) && n < limit) begin
            @(negedge CLOCK_50);
            n++;
        end
        checks++;
        assert (irq_level(which)) else begin
            $display("timeout at %0t: %s did not rise within %0d cycles", $time, what, limit);
            errors++;
        end
    endtask

    task automatic pulse_irq(input src_vec_t m);
        @(negedge CLOCK_50);
        irq_src = m;
        @(negedge CLOCK_50);
        irq_src = '0;
        m_pend = m_pend | m;
    endtask

    task automatic set_prio(input int id, input prio_t p);
        write_reg(PLIC_BASE + addr_t'(4 * id), data_t'(p));
        m_prio[id] = p;
    endtask

    // claim read, the model drops the returned pending bit
    task automatic claim_check(input int c);
        logic [2:0] exp;
        exp = model_claim(c);
        read_check(c == 0 ? PLIC_CLAIM0 : PLIC_CLAIM1, data_t'(exp), "claim id");
        if (exp != 3'd0) begin
            m_pend[exp - 3'd1] = 1'b0;
        end
    endtask

    task automatic pending_check();
        read_check(PLIC_PENDING, data_t'({m_pend, 1'b0}), "pending bitmap");
    endtask

    // table entry, model updated in table order
    task automatic add_op(input bit wr, input ls_type_e ls, input int off, input data_t d);
        op_t   op;
        addr_t a;
        a = RAM_BASE + addr_t'(off);
        if (wr) begin
            model_store(ls, a, d);
        end
        op.wr   = wr;
        op.ls   = ls;
        op.addr = a;
        op.data = d;
        op.exp  = wr ? '0 : model_load(ls, a);
        ops.push_back(op);
    endtask

    task automatic run_table();
        data_t rd;
        foreach (ops[i]) begin
            access(ops[i].wr, ops[i].ls, ops[i].addr, ops[i].data, rd);
            if (!ops[i].wr) begin
                check_value(rd, ops[i].exp, $sformatf("%s at %h", ops[i].ls.name(), ops[i].addr));
            end
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        data_t t1;
        data_t t2;
        data_t rd;
        void'($urandom(32'h4dab));
        KEY0       = 1'b0;
        bus_req    = '0;
        irq_src    = '0;
        errors     = 0;
        checks     = 0;
        test_start = 0;
        m_pend     = '0;
        m_en[0]    = '0;
        m_en[1]    = '0;
        m_thr[0]   = '0;
        m_thr[1]   = '0;
        for (int n = 0; n <= NUM_SOURCES; n++) begin
            m_prio[n] = '0;
        end
        repeat (2) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;

        // reset state
        @(negedge CLOCK_50);
        check_value(data_t'({bus_rsp.read_done, bus_rsp.write_done}), 64'd3, "done flags");
        check_value(data_t'({meip, seip, mtip}), 64'd0, "interrupt outputs");
        read_check(MTIMECMP_ADDR, 64'h8000_0000, "mtimecmp reset value");
        end_test("reset");

        // stores of every width, then every load type
        for (int i = 0; i < 4; i++) begin
            add_op(1'b1, LS_B, 'h10 + i, data_t'($urandom));
        end
        add_op(1'b1, LS_H, 'h14, data_t'($urandom));
        add_op(1'b1, LS_H, 'h16, data_t'($urandom));
        add_op(1'b1, LS_W, 'h18, data_t'($urandom));
        add_op(1'b1, LS_W, 'h1c, data_t'($urandom));
        add_op(1'b1, LS_D, 'h20, {$urandom, $urandom});
        for (int o = 0; o < 8; o++) begin
            add_op(1'b0, LS_B, 'h10 + o, '0);
            add_op(1'b0, LS_BU, 'h10 + o, '0);
        end
        for (int o = 0; o < 8; o += 2) begin
            add_op(1'b0, LS_H, 'h10 + o, '0);
            add_op(1'b0, LS_HU, 'h10 + o, '0);
        end
        for (int o = 0; o < 24; o += 4) begin
            add_op(1'b0, LS_W, 'h10 + o, '0);
            add_op(1'b0, LS_WU, 'h10 + o, '0);
        end
        add_op(1'b0, LS_D, 'h10, '0);
        add_op(1'b0, LS_D, 'h18, '0);
        add_op(1'b0, LS_D, 'h20, '0);
        run_table();
        end_test("ram");

        // mtime runs, compare a little ahead of it
        access(1'b0, LS_D, MTIME_ADDR, '0, t1);
        access(1'b0, LS_D, MTIME_ADDR, '0, t2);
        checks++;
        assert (t2 > t1) else begin
            $display("mismatch at %0t: mtime did not advance, %h then %h", $time, t1, t2);
            errors++;
        end
        access(1'b1, LS_D, MTIMECMP_ADDR, t2 + 64'd40, rd);
        wait_high(2, 80, "mtip");
        end_test("timer");

        // context 0 claims in priority order
        set_prio(2, 3'd3);
        set_prio(4, 3'd5);
        write_reg(PLIC_ENABLE0, 64'h14);
        m_en[0] = 5'b01010;
        write_reg(PLIC_THRESHOLD0, 64'd0);
        m_thr[0] = 3'd0;
        pulse_irq(5'b01010);
        wait_high(0, 10, "meip");
        pending_check();
        for (int k = 0; k < 3; k++) begin
            claim_check(0);
            pending_check();
        end
        @(negedge CLOCK_50);
        check_value(data_t'(meip), 64'd0, "meip after claims");
        end_test("claim0");

        // source 1 only in context 1, blocked by threshold
        set_prio(1, 3'd2);
        write_reg(PLIC_ENABLE1, 64'h2);
        m_en[1] = 5'b00001;
        write_reg(PLIC_THRESHOLD1, 64'd2);
        m_thr[1] = 3'd2;
        pulse_irq(5'b00001);
        repeat (3) @(negedge CLOCK_50);
        check_value(data_t'(seip), data_t'(model_claim(1) != 3'd0), "seip at threshold 2");
        check_value(data_t'(meip), 64'd0, "meip with source 1 pending");
        write_reg(PLIC_THRESHOLD1, 64'd1);
        m_thr[1] = 3'd1;
        wait_high(1, 10, "seip");
        claim_check(1);
        pending_check();
        end_test("claim1");

        // nonzero read data first, so a stale value cannot pass as zero
        read_check(PLIC_BASE + 64'h10, data_t'(m_prio[4]), "priority of source 4");
        read_check(64'h4000_0000, 64'd0, "unmapped read");
        access(1'b1, LS_W, 64'h4000_0000, data_t'($urandom), rd);
        end_test("unmapped");

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- soc_bus.f
src/soc_pkg.sv
src/bus_decoder.sv
src/bus_sequencer.sv
src/word_ram.sv
src/clint_timer.sv
src/plic_lite.sv
src/soc_bus.sv
tests/soc_bus_assertions.sv
tests/soc_bus_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the soc_bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f soc_bus.f --top-module soc_bus_tb \
    -o soc_bus_sim > build.log 2>&1 \
    && ./obj_dir/soc_bus_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation reported success"; exit 0; }
